// ==== lsu_macros.svh ====
// widths, RAM depth, hit latencies and response bound for the load/store path
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data and address width
`define LSU_XLEN 32

// RAM depth in words, upper address bits are ignored
`define LSU_RAM_WORDS 256

// hit delay in cycles, chosen by word index bit 2
`define LSU_HIT_FAST 1
`define LSU_HIT_SLOW 3

// worst case cycles from request to response
`define LSU_RSP_TIMEOUT 12

`endif

// ==== lsu_pkg.sv ====
// lsu_pkg: operation, width and state enums plus the stage-to-stage structs
`include "lsu_macros.svh"

package lsu_pkg;

    typedef enum logic [1:0] {OP_NONE, OP_LOAD, OP_STORE} mem_op_e;

    typedef enum logic [1:0] {BYTE, HALFWORD, WORD} data_width_e;

    typedef enum logic [1:0] {IDLE, READ, WRITE} mem_state_e;

    // decode to execute
    typedef struct packed {
        logic                 valid;
        mem_op_e              op;
        data_width_e          width;
        logic                 unsigned_load;
        logic [`LSU_XLEN-1:0] base;
        logic [`LSU_XLEN-1:0] offset;
        logic [`LSU_XLEN-1:0] store_data;
    } dec_op_t;

    // execute to memory, data already placed in byte lanes
    typedef struct packed {
        logic                 valid;
        mem_op_e              op;
        data_width_e          width;
        logic                 unsigned_load;
        logic                 misaligned;
        logic [`LSU_XLEN-1:0] addr;
        logic [`LSU_XLEN-1:0] data;
        logic [3:0]           be;
    } mem_req_t;

    // memory to result
    typedef struct packed {
        logic                 valid;
        mem_op_e              op;
        data_width_e          width;
        logic                 unsigned_load;
        logic                 misaligned;
        logic [1:0]           addr_lo;
        logic [`LSU_XLEN-1:0] raw;
    } mem_rsp_t;

    typedef struct packed {
        logic                 valid;
        logic                 is_load;
        logic                 misaligned;
        logic [`LSU_XLEN-1:0] result;
    } lsu_rsp_t;

endpackage

// ==== lsu_decode.sv ====
// lsu_decode: turns a memory instruction word into a registered dec_op_t
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_decode
    import lsu_pkg::*;
(
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 req_valid,
    input  logic [`LSU_XLEN-1:0] instr,
    input  logic [`LSU_XLEN-1:0] rs1,
    input  logic [`LSU_XLEN-1:0] rs2,
    output dec_op_t              dec
);
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [`LSU_XLEN-1:0] imm_i;
    logic [`LSU_XLEN-1:0] imm_s;
    dec_op_t              dec_next;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // both immediates sign extend from bit 31
    assign imm_i = {{(`LSU_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`LSU_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};

    always_comb begin
        dec_next            = '0;
        dec_next.valid      = req_valid;
        dec_next.base       = rs1;
        dec_next.store_data = rs2;

        // funct3 low bits give the size, bit 2 marks LBU/LHU
        case (funct3[1:0])
            2'b00:   dec_next.width = BYTE;
            2'b01:   dec_next.width = HALFWORD;
            default: dec_next.width = WORD;
        endcase
        dec_next.unsigned_load = funct3[2];

        if (opcode == OPC_LOAD) begin
            if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                dec_next.op     = OP_LOAD;
                dec_next.offset = imm_i;
            end
        end else if (opcode == OPC_STORE) begin
            if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
                dec_next.op     = OP_STORE;
                dec_next.offset = imm_s;
            end
        end

        // anything else stays OP_NONE and is answered as a non-load
        if (dec_next.op != OP_LOAD) begin
            dec_next.unsigned_load = 1'b0;
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            dec <= '0;
        end else begin
            dec <= dec_next;
        end
    end

endmodule

// ==== lsu_agen.sv ====
// lsu_agen: effective address, alignment check and store lane placement
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_agen
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     nRST,
    input  dec_op_t  dec,
    output mem_req_t req
);
    logic [`LSU_XLEN-1:0] addr;
    logic                 is_mem;
    logic                 misaligned;
    mem_req_t             req_next;

    assign addr   = dec.base + dec.offset;
    assign is_mem = (dec.op != OP_NONE);

    always_comb begin
        case (dec.width)
            HALFWORD: misaligned = is_mem && addr[0];
            WORD:     misaligned = is_mem && (addr[1:0] != 2'b00);
            default:  misaligned = 1'b0;
        endcase
    end

    always_comb begin
        req_next               = '0;
        req_next.valid         = dec.valid;
        req_next.op            = dec.op;
        req_next.width         = dec.width;
        req_next.unsigned_load = dec.unsigned_load;
        req_next.misaligned    = misaligned;
        req_next.addr          = addr;

        // replicate the store value so every lane carries it
        case (dec.width)
            BYTE: begin
                req_next.data = {4{dec.store_data[7:0]}};
                req_next.be   = 4'b0001 << addr[1:0];
            end
            HALFWORD: begin
                req_next.data = {2{dec.store_data[15:0]}};
                req_next.be   = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                req_next.data = dec.store_data;
                req_next.be   = 4'b1111;
            end
        endcase

        // loads and bad addresses write nothing
        if (dec.op != OP_STORE || misaligned) begin
            req_next.be = 4'b0000;
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            req <= '0;
        end else begin
            req <= req_next;
        end
    end

endmodule

// ==== data_memory.sv ====
// data_memory: request FSM driving the data RAM and building mem_rsp_t
`timescale 1ns/1ps
`include "lsu_macros.svh"

module data_memory
    import lsu_pkg::*;
(
    input  logic                 clk,
    input  logic                 nRST,
    input  mem_req_t             req,
    input  logic [`LSU_XLEN-1:0] rdata,
    input  logic                 dhit,
    output logic                 data_read,
    output logic                 data_write,
    output logic [`LSU_XLEN-1:0] ram_addr,
    output logic [`LSU_XLEN-1:0] ram_wdata,
    output logic [3:0]           ram_be,
    output mem_rsp_t             rsp
);
    mem_state_e state;
    mem_state_e next_state;
    mem_req_t   held;
    logic       take;
    logic       bypass;

    function automatic mem_rsp_t make_rsp(input mem_req_t r, input logic [`LSU_XLEN-1:0] raw);
        mem_rsp_t m;
        m.valid         = 1'b1;
        m.op            = r.op;
        m.width         = r.width;
        m.unsigned_load = r.unsigned_load;
        m.misaligned    = r.misaligned;
        m.addr_lo       = r.addr[1:0];
        m.raw           = raw;
        return m;
    endfunction

    // only one request in flight, so a new one is taken from IDLE
    assign take   = (state == IDLE) && req.valid;
    assign bypass = req.misaligned || (req.op == OP_NONE);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (take && !bypass) begin
                    next_state = (req.op == OP_LOAD) ? READ : WRITE;
                end
            end
            READ, WRITE: begin
                if (dhit) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            rsp   <= '0;
        end else begin
            state     <= next_state;
            rsp.valid <= 1'b0;
            if (take && bypass) begin
                // answered without touching the RAM
                rsp <= make_rsp(req, '0);
            end else if (state == READ && dhit) begin
                rsp <= make_rsp(held, rdata);
            end else if (state == WRITE && dhit) begin
                rsp <= make_rsp(held, '0);
            end
        end
    end

    // request kept for the whole access
    always_ff @(posedge clk) begin
        if (take) begin
            held <= req;
        end
    end

    // strobes come straight from the state, so they stay up until dhit
    assign data_read  = (state == READ);
    assign data_write = (state == WRITE);
    assign ram_addr   = held.addr;
    assign ram_wdata  = held.data;
    assign ram_be     = held.be;

endmodule

// ==== data_ram.sv ====
// data_ram: byte-enabled word RAM with an address dependent hit delay
`timescale 1ns/1ps
`include "lsu_macros.svh"

module data_ram (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 data_read,
    input  logic                 data_write,
    input  logic [`LSU_XLEN-1:0] ram_addr,
    input  logic [`LSU_XLEN-1:0] ram_wdata,
    input  logic [3:0]           ram_be,
    output logic [`LSU_XLEN-1:0] rdata,
    output logic                 dhit
);
    localparam int IDX_W = $clog2(`LSU_RAM_WORDS);

    logic [`LSU_XLEN-1:0] mem [`LSU_RAM_WORDS];
    logic [IDX_W-1:0]     idx;
    logic                 strobe;
    logic                 active;
    logic [1:0]           cnt;
    logic [1:0]           hit_delay;
    logic                 hit_next;

    assign idx    = ram_addr[IDX_W+1:2];
    assign strobe = data_read || data_write;

    // word index bit 2 picks the slow bank
    assign hit_delay = idx[2] ? 2'(`LSU_HIT_SLOW) : 2'(`LSU_HIT_FAST);

    // a new access starts only when no hit is pending or showing
    assign hit_next = active ? (cnt == 2'd0)
                             : (strobe && !dhit && hit_delay == 2'd1);

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            active <= 1'b0;
            cnt    <= 2'd0;
            dhit   <= 1'b0;
        end else begin
            dhit <= hit_next;
            if (active) begin
                if (cnt == 2'd0) begin
                    active <= 1'b0;
                end else begin
                    cnt <= cnt - 2'd1;
                end
            end else if (strobe && !dhit && hit_delay != 2'd1) begin
                active <= 1'b1;
                cnt    <= hit_delay - 2'd2;
            end
        end
    end

    // access lands on the edge that raises dhit
    always_ff @(posedge clk) begin
        if (hit_next) begin
            rdata <= mem[idx];
            if (data_write) begin
                for (int b = 0; b < 4; b++) begin
                    if (ram_be[b]) begin
                        mem[idx][8*b +: 8] <= ram_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    initial begin
        for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

endmodule

// ==== load_format.sv ====
// load_format: lane extraction, sign or zero extension and the response strobe
`timescale 1ns/1ps
`include "lsu_macros.svh"

module load_format
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     nRST,
    input  mem_rsp_t mrsp,
    output lsu_rsp_t rsp
);
    logic [7:0]           lane_byte;
    logic [15:0]          lane_half;
    logic                 good_load;
    logic [`LSU_XLEN-1:0] result;

    // pick the addressed lane out of the raw word
    assign lane_byte = mrsp.raw[8*mrsp.addr_lo +: 8];
    assign lane_half = mrsp.addr_lo[1] ? mrsp.raw[31:16] : mrsp.raw[15:0];
    assign good_load = (mrsp.op == OP_LOAD) && !mrsp.misaligned;

    always_comb begin
        result = '0;
        if (good_load) begin
            case (mrsp.width)
                BYTE: begin
                    result = mrsp.unsigned_load ? {24'b0, lane_byte}
                                                : {{24{lane_byte[7]}}, lane_byte};
                end
                HALFWORD: begin
                    result = mrsp.unsigned_load ? {16'b0, lane_half}
                                                : {{16{lane_half[15]}}, lane_half};
                end
                default: result = mrsp.raw;
            endcase
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            rsp <= '0;
        end else begin
            rsp.valid      <= mrsp.valid;
            rsp.is_load    <= (mrsp.op == OP_LOAD);
            rsp.misaligned <= mrsp.misaligned;
            rsp.result     <= result;
        end
    end

endmodule

// ==== lsu_top.sv ====
// lsu_top: decode, execute, memory access, data RAM and result stages
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 req_valid,
    input  logic [`LSU_XLEN-1:0] instr,
    input  logic [`LSU_XLEN-1:0] rs1,
    input  logic [`LSU_XLEN-1:0] rs2,
    output lsu_rsp_t             rsp
);
    dec_op_t              dec;
    mem_req_t             req;
    mem_rsp_t             mrsp;
    logic                 data_read;
    logic                 data_write;
    logic [`LSU_XLEN-1:0] ram_addr;
    logic [`LSU_XLEN-1:0] ram_wdata;
    logic [3:0]           ram_be;
    logic [`LSU_XLEN-1:0] rdata;
    logic                 dhit;

    lsu_decode i_lsu_decode (
        .clk(clk), .nRST(nRST), .req_valid(req_valid),
        .instr(instr), .rs1(rs1), .rs2(rs2), .dec(dec)
    );

    lsu_agen i_lsu_agen (.clk(clk), .nRST(nRST), .dec(dec), .req(req));

    data_memory i_data_memory (
        .clk(clk), .nRST(nRST), .req(req), .rdata(rdata), .dhit(dhit),
        .data_read(data_read), .data_write(data_write), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_be(ram_be), .rsp(mrsp)
    );

    data_ram i_data_ram (
        .clk(clk), .nRST(nRST), .data_read(data_read), .data_write(data_write),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_be(ram_be),
        .rdata(rdata), .dhit(dhit)
    );

    load_format i_load_format (.clk(clk), .nRST(nRST), .mrsp(mrsp), .rsp(rsp));

endmodule

// ==== lsu_assertions.sv ====
// lsu_assertions: concurrent protocol checks bound into lsu_top
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_assertions
    import lsu_pkg::*;
(
    input logic     clk,
    input logic     nRST,
    input logic     req_valid,
    input lsu_rsp_t rsp,
    input logic     data_read,
    input logic     data_write,
    input logic     dhit
);
    logic       outstanding;
    logic [4:0] wait_cnt;

    // tracks the single request in flight
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            outstanding <= 1'b0;
            wait_cnt    <= '0;
        end else if (req_valid) begin
            outstanding <= 1'b1;
            wait_cnt    <= '0;
        end else if (rsp.valid) begin
            outstanding <= 1'b0;
            wait_cnt    <= '0;
        end else if (outstanding) begin
            wait_cnt <= wait_cnt + 5'd1;
        end
    end

    a_strobes_exclusive: assert property (@(posedge clk) disable iff (!nRST)
        !(data_read && data_write))
        else $error("data_read and data_write high together");

    a_read_held: assert property (@(posedge clk) disable iff (!nRST)
        data_read && !dhit |=> data_read)
        else $error("data_read dropped before dhit");

    a_write_held: assert property (@(posedge clk) disable iff (!nRST)
        data_write && !dhit |=> data_write)
        else $error("data_write dropped before dhit");

    a_rsp_pulse: assert property (@(posedge clk) disable iff (!nRST)
        rsp.valid |=> !rsp.valid)
        else $error("rsp.valid longer than one cycle");

    // response must come within the bound
    a_rsp_in_time: assert property (@(posedge clk) disable iff (!nRST)
        outstanding |-> wait_cnt < 5'(`LSU_RSP_TIMEOUT))
        else $error("response later than the bound");

    a_one_in_flight: assert property (@(posedge clk) disable iff (!nRST)
        req_valid |-> !outstanding)
        else $error("request issued while one is outstanding");

endmodule

bind lsu_top lsu_assertions i_lsu_assertions (.*);

// ==== lsu_tb.sv ====
// lsu_tb: clock, reset, directed and random load/store traffic against a byte model
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_tb
    import lsu_pkg::*;
;
    logic        clk;
    logic        nRST;
    logic        req_valid;
    logic [31:0] instr;
    logic [31:0] rs1;
    logic [31:0] rs2;
    lsu_rsp_t    rsp;

    logic [7:0]  ref_mem [4*`LSU_RAM_WORDS];
    int          error_count;
    int          timeout_count;
    int          seed;

    lsu_top i_lsu_top (
        .clk(clk), .nRST(nRST), .req_valid(req_valid),
        .instr(instr), .rs1(rs1), .rs2(rs2), .rsp(rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // I-type load, rd x1, base x2
    function automatic logic [31:0] load_instr(input logic [2:0] f3, input logic [11:0] imm);
        return {imm, 5'd2, f3, 5'd1, 7'b0000011};
    endfunction

    // S-type store, data x3, base x2
    function automatic logic [31:0] store_instr(input logic [2:0] f3, input logic [11:0] imm);
        return {imm[11:5], 5'd3, 5'd2, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic is_misaligned(input logic [2:0] f3, input logic [31:0] addr);
        if (f3[1:0] == 2'b01) begin
            return addr[0];
        end else if (f3[1:0] == 2'b10) begin
            return addr[1:0] != 2'b00;
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] model_load(input logic [2:0] f3, input logic [31:0] addr);
        logic [9:0] a;
        logic [7:0] b0;
        logic [7:0] b1;
        a  = addr[9:0];
        b0 = ref_mem[a];
        b1 = ref_mem[10'(a + 10'd1)];
        case (f3)
            3'b000:  return {{24{b0[7]}}, b0};
            3'b100:  return {24'b0, b0};
            3'b001:  return {{16{b1[7]}}, b1, b0};
            3'b101:  return {16'b0, b1, b0};
            default: return {ref_mem[10'(a + 10'd3)], ref_mem[10'(a + 10'd2)], b1, b0};
        endcase
    endfunction

    task automatic issue(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b,
                         output lsu_rsp_t got);
        int waited;
        @(negedge clk);
        req_valid = 1'b1;
        instr     = ins;
        rs1       = a;
        rs2       = b;
        @(negedge clk);
        req_valid = 1'b0;
        waited    = 1;
        got       = '0;
        while (!rsp.valid && waited < `LSU_RSP_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (rsp.valid) begin
            got = rsp;
        end else begin
            $display("Timeout: no response within %0d cycles for instruction %h",
                     `LSU_RSP_TIMEOUT, ins);
            timeout_count++;
        end
    endtask

    task automatic check_rsp(input lsu_rsp_t got, input logic exp_load, input logic exp_mis,
                             input logic [31:0] exp_result, input logic [31:0] ins);
        if (got.valid) begin
            if (got.is_load !== exp_load || got.misaligned !== exp_mis ||
                got.result !== exp_result) begin
                $display("FAILED at %0t: instr %h got load %b mis %b result %h, expected %b %b %h",
                         $time, ins, got.is_load, got.misaligned, got.result,
                         exp_load, exp_mis, exp_result);
                error_count++;
            end
        end
    endtask

    task automatic do_load(input logic [2:0] f3, input logic [31:0] base, input logic [11:0] imm);
        lsu_rsp_t    got;
        logic [31:0] addr;
        logic [31:0] ins;
        logic        mis;
        ins  = load_instr(f3, imm);
        addr = base + {{20{imm[11]}}, imm};
        mis  = is_misaligned(f3, addr);
        issue(ins, base, 32'h0, got);
        check_rsp(got, 1'b1, mis, mis ? 32'h0 : model_load(f3, addr), ins);
    endtask

    task automatic do_store(input logic [2:0] f3, input logic [31:0] base, input logic [11:0] imm,
                            input logic [31:0] data);
        lsu_rsp_t    got;
        logic [31:0] addr;
        logic [31:0] ins;
        logic        mis;
        ins  = store_instr(f3, imm);
        addr = base + {{20{imm[11]}}, imm};
        mis  = is_misaligned(f3, addr);
        issue(ins, base, data, got);
        if (!mis) begin
            ref_mem[addr[9:0]] = data[7:0];
            if (f3 != 3'b000) begin
                ref_mem[10'(addr[9:0] + 10'd1)] = data[15:8];
            end
            if (f3 == 3'b010) begin
                ref_mem[10'(addr[9:0] + 10'd2)] = data[23:16];
                ref_mem[10'(addr[9:0] + 10'd3)] = data[31:24];
            end
        end
        check_rsp(got, 1'b0, mis, 32'h0, ins);
    endtask

    initial begin
        lsu_rsp_t    got;
        logic [31:0] r;
        logic [31:0] base;
        logic [11:0] imm;
        logic [2:0]  sel;
        nRST          = 1'b0;
        req_valid     = 1'b0;
        instr         = '0;
        rs1           = '0;
        rs2           = '0;
        error_count   = 0;
        timeout_count = 0;
        seed          = 32'h9a4a96ab;
        for (int i = 0; i < 4 * `LSU_RAM_WORDS; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (4) @(negedge clk);
        nRST = 1'b1;

        // word store and load, fast bank then slow bank
        do_store(3'b010, 32'h0, 12'h0, 32'hdeadbeef);
        do_load(3'b010, 32'h0, 12'h0);
        do_store(3'b010, 32'h10, 12'h0, 32'h12345678);
        do_load(3'b010, 32'h10, 12'h0);

        // byte and halfword stores in every lane
        for (int b = 0; b < 4; b++) begin
            do_store(3'b000, 32'h20, 12'(b), 32'h80 + 32'(b));
            do_load(3'b010, 32'h20, 12'h0);
        end
        do_store(3'b001, 32'h30, 12'h0, 32'h0000a5c3);
        do_load(3'b010, 32'h30, 12'h0);
        do_store(3'b001, 32'h30, 12'h2, 32'h0000f00d);
        do_load(3'b010, 32'h30, 12'h0);

        // extension on lanes with the top bit set
        do_store(3'b010, 32'h40, 12'h0, 32'h8091a2f3);
        for (int b = 0; b < 4; b++) begin
            do_load(3'b000, 32'h40, 12'(b));
            do_load(3'b100, 32'h40, 12'(b));
        end
        do_load(3'b001, 32'h40, 12'h0);
        do_load(3'b101, 32'h40, 12'h0);
        do_load(3'b001, 32'h40, 12'h2);
        do_load(3'b101, 32'h40, 12'h2);

        // misaligned accesses leave memory alone
        do_load(3'b001, 32'h40, 12'h1);
        do_load(3'b010, 32'h40, 12'h2);
        do_store(3'b001, 32'h40, 12'h3, 32'hffffffff);
        do_store(3'b010, 32'h40, 12'h1, 32'hffffffff);
        do_load(3'b010, 32'h40, 12'h0);

        // R-type opcode, not a memory op
        issue(32'h00000033, 32'h40, 32'h1, got);
        check_rsp(got, 1'b0, 1'b0, 32'h0, 32'h00000033);

        for (int n = 0; n < 200; n++) begin
            r    = $random(seed);
            sel  = r[2:0];
            base = 32'd16 + ($unsigned($random(seed)) % 32'd224);
            imm  = 12'($random(seed) % 16);
            r    = $random(seed);
            case (sel)
                3'd0: do_load(3'b000, base, imm);
                3'd1: do_load(3'b001, base, imm);
                3'd2: do_load(3'b010, base, imm);
                3'd3: do_load(3'b100, base, imm);
                3'd4: do_load(3'b101, base, imm);
                3'd5: do_store(3'b000, base, imm, r);
                3'd6: do_store(3'b001, base, imm, r);
                default: do_store(3'b010, base, imm, r);
            endcase
        end

        repeat (2) @(negedge clk);
        $display("errors: %0d wrong values, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
lsu_pkg.sv
lsu_decode.sv
lsu_agen.sv
data_memory.sv
data_ram.sv
load_format.sv
lsu_top.sv
lsu_assertions.sv
lsu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the load/store path testbench with Verilator
cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing --assert -f sim.f --top-module lsu_tb 2>&1 \
    && ./obj_dir/Vlsu_tb 2>&1)
echo "$out"

echo "$out" | grep -q "Simulation completed successfully" && exit 0 || exit 1
